// File: keypad_calc_top.f
verilog/keypad_calc_pkg.sv
verilog/keypad_scanner.sv
verilog/operand_entry.sv
verilog/shift_add_multiplier.sv
verilog/bin_to_bcd.sv
verilog/display_mux.sv
verilog/keypad_calc_top.sv
verif/keypad_calc_assertions.sv
verif/keypad_calc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the keypad multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module keypad_calc_tb -f keypad_calc_top.f
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vkeypad_calc_tb +verilator+error+limit+1000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification passed" <<< "$output"; then
    exit 0
fi
echo "Simulation did not report success"
exit 1

// File: verif/keypad_calc_assertions.sv
// Keypad multiplier assertions
// One-hot scan and digit select, multiplier latency, single key pulses

`timescale 1ns/1ns

module keypad_calc_assertions (
    input logic                   clk,
    input logic                   rst,
    input keypad_calc_pkg::line_t row,
    input keypad_calc_pkg::line_t digit_sel,
    input logic                   start,
    input logic                   done_pulse,
    input logic                   key_valid
);
    import keypad_calc_pkg::*;

    localparam int MULT_CYCLES = OPERAND_BITS + 1;

    int fail_count = 0;  // Summed into the testbench error count

    row_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(row))
        else begin
            $error("row is not one-hot: %b", row);
            fail_count++;
        end

    digit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(digit_sel))
        else begin
            $error("digit_sel is not one-hot: %b", digit_sel);
            fail_count++;
        end

    // done_pulse exactly MULT_CYCLES after start, and never otherwise
    done_after_start: assert property (@(posedge clk) disable iff (rst)
        $past(start, MULT_CYCLES) |-> done_pulse)
        else begin
            $error("done_pulse missing after start");
            fail_count++;
        end

    done_needs_start: assert property (@(posedge clk) disable iff (rst)
        done_pulse |-> $past(start, MULT_CYCLES))
        else begin
            $error("done_pulse without a matching start");
            fail_count++;
        end

    key_single: assert property (@(posedge clk) disable iff (rst) key_valid |=> !key_valid)
        else begin
            $error("key_valid high for two cycles");
            fail_count++;
        end

endmodule

bind keypad_calc_top keypad_calc_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .row        (row),
    .digit_sel  (digit_sel),
    .start      (start),
    .done_pulse (done_pulse),
    .key_valid  (key_valid)
);

// File: verif/keypad_calc_tb.sv
// Keypad multiplier testbench
// Presses keys on a keypad model and reads the multiplexed display back

`timescale 1ns/1ns

module keypad_calc_tb;
    import keypad_calc_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int HOLD_CYCLES  = 12;   // Press time, also release time
    localparam int WAIT_LIMIT   = 200;  // Cycles before a wait gives up

    logic  clk = 1'b0;
    logic  rst;
    line_t col = '0;
    line_t row;
    seg_t  seg;
    line_t digit_sel;
    logic  done;

    logic        key_down = 1'b0;
    key_code_t   key_sel = '0;
    logic [16:0] lfsr_state = 17'd69033;
    int          errors = 0;
    int          test_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    keypad_calc_top dut (
        .clk       (clk),
        .rst       (rst),
        .col       (col),
        .row       (row),
        .seg       (seg),
        .digit_sel (digit_sel),
        .done      (done)
    );

    always #5 clk = ~clk;

    // Pressed key connects its row to its column
    always @(negedge clk) begin
        if (key_down && row[key_sel[3:2]]) begin
            col <= line_t'(1) << key_sel[1:0];
        end else begin
            col <= '0;
        end
    end

    //******************************
    // Reference and helpers
    //******************************
    function automatic key_code_t digit_key(input int d);
        if (d == 0) return key_code_t'(KEY_ZERO);
        return key_code_t'(((d - 1) / 3) * 4 + (d - 1) % 3);  // 1..9 fill rows 0..2
    endfunction

    // Four BCD digits of a * b, thousands first
    function automatic logic [15:0] expected_digits(input int a, input int b);
        int p;
        p = a * b;
        return {4'(p / 1000), 4'(p / 100 % 10), 4'(p / 10 % 10), 4'(p % 10)};
    endfunction

    function automatic logic [3:0] seg_to_digit(input seg_t s);
        case (s)
            7'b0111111: return 4'h0;
            7'b0000110: return 4'h1;
            7'b1011011: return 4'h2;
            7'b1001111: return 4'h3;
            7'b1100110: return 4'h4;
            7'b1101101: return 4'h5;
            7'b1111101: return 4'h6;
            7'b0000111: return 4'h7;
            7'b1111111: return 4'h8;
            7'b1101111: return 4'h9;
            7'b0000000: return 4'hF;  // Blank digit
            default:    return 4'hE;  // No valid pattern
        endcase
    endfunction

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic random_operand(output int v);
        logic [6:0] bits;
        for (int i = 0; i < 7; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits[i] = lfsr_state[0];
        end
        v = int'(bits) % 100;
    endtask

    task automatic check(input string name, input logic [15:0] got,
                         input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    //******************************
    // Stimulus and reading
    //******************************
    task automatic press_key(input key_code_t code, input int hold);
        @(negedge clk);
        key_sel  <= code;
        key_down <= 1'b1;
        repeat (hold) @(negedge clk);
        key_down <= 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk);
    endtask

    task automatic enter_number(input int n);
        press_key(digit_key(n / 10), HOLD_CYCLES);
        press_key(digit_key(n % 10), HOLD_CYCLES);
    endtask

    // Digits packed thousands first, blank reads as F
    task automatic read_display(output logic [15:0] val);
        int waited;
        for (int pos = 0; pos < NUM_DIGITS; pos++) begin
            waited = 0;
            while (digit_sel !== line_t'(1 << pos) && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (digit_sel !== line_t'(1 << pos)) begin
                $display("Timeout: display digit %0d was never selected", pos);
                errors++;
            end
            val[pos*4 +: 4] = seg_to_digit(seg);
        end
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        while (done !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (done !== 1'b1) begin
            $display("Timeout: done did not go high after the equals key");
            errors++;
        end
    endtask

    task automatic multiply(input int a, input int b);
        logic [15:0] shown;
        enter_number(a);
        press_key(key_code_t'(KEY_MUL), HOLD_CYCLES);
        enter_number(b);
        press_key(key_code_t'(KEY_EQ), HOLD_CYCLES);
        wait_for_done();
        read_display(shown);
        check("display", shown, expected_digits(a, b));
    endtask

    initial begin
        logic [15:0] shown;
        int          a;
        int          b;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        check("done", 16'(done), 16'h0);
        check("digit_sel", 16'(digit_sel), 16'h1);
        check("row", 16'(row), 16'h1);
        read_display(shown);
        check("display", shown, 16'hFF00);
        finish_test("reset state");

        press_key(digit_key(4), HOLD_CYCLES);
        press_key(digit_key(7), HOLD_CYCLES);
        check("done", 16'(done), 16'h0);
        read_display(shown);
        check("display", shown, 16'hFF47);
        press_key(digit_key(2), HOLD_CYCLES);
        read_display(shown);
        check("display", shown, 16'hFF72);
        finish_test("digit entry");

        press_key(4'd3, HOLD_CYCLES);   // A
        press_key(4'd15, HOLD_CYCLES);  // D
        press_key(4'd12, HOLD_CYCLES);  // E
        press_key(4'd14, HOLD_CYCLES);  // F
        press_key(key_code_t'(KEY_EQ), HOLD_CYCLES);
        check("done", 16'(done), 16'h0);
        read_display(shown);
        check("display", shown, 16'hFF72);
        finish_test("ignored keys");

        // Second operand starts from cleared digits
        press_key(key_code_t'(KEY_MUL), HOLD_CYCLES);
        press_key(digit_key(8), 60);
        read_display(shown);
        check("display", shown, 16'hFF08);
        press_key(key_code_t'(KEY_EQ), HOLD_CYCLES);
        wait_for_done();
        read_display(shown);
        check("display", shown, expected_digits(72, 8));
        finish_test("held key");

        multiply(12, 34);
        for (int i = 0; i < 20; i++) begin
            random_operand(a);
            random_operand(b);
            if (i == 0) begin
                a = 99;
                b = 99;
            end
            if (i == 1) a = 0;
            multiply(a, b);
        end
        finish_test("multiplication");

        press_key(digit_key(6), HOLD_CYCLES);
        check("done", 16'(done), 16'h0);
        read_display(shown);
        check("display", shown, 16'hFF06);
        finish_test("new entry");

        if (dut.u_assertions.fail_count != 0) begin
            $display("Assertion failures: %0d", dut.u_assertions.fail_count);
            errors += dut.u_assertions.fail_count;
        end
        $display("Tests run: %0d, tests failed: %0d, errors: %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog/bin_to_bcd.sv
// Binary to BCD converter
// Combinational double dabble over the product bits

`timescale 1ns/1ns

module bin_to_bcd (
    input  keypad_calc_pkg::product_t product,
    output keypad_calc_pkg::bcd_t     result_digits [keypad_calc_pkg::NUM_DIGITS]
);
    import keypad_calc_pkg::*;

    logic [4*NUM_DIGITS-1:0] bcd;

    always_comb begin
        bcd = '0;
        for (int i = PRODUCT_BITS - 1; i >= 0; i--) begin
            // Add 3 to any digit of 5 or more before it doubles
            for (int d = 0; d < NUM_DIGITS; d++) begin
                if (bcd[d*4 +: 4] >= 4'd5) begin
                    bcd[d*4 +: 4] = bcd[d*4 +: 4] + 4'd3;
                end
            end
            bcd = {bcd[4*NUM_DIGITS-2:0], product[i]};
        end
    end

    // Digit 0 is units
    always_comb begin
        for (int d = 0; d < NUM_DIGITS; d++) begin
            result_digits[d] = bcd[d*4 +: 4];
        end
    end

endmodule

// File: verilog/display_mux.sv
// Multiplexed seven-segment driver
// Shows entry digits or the four result digits, one digit at a time

`timescale 1ns/1ns

module display_mux (
    input  logic                   clk,
    input  logic                   rst,
    input  keypad_calc_pkg::bcd_t  entry_tens,
    input  keypad_calc_pkg::bcd_t  entry_units,
    input  logic                   show_result,
    input  keypad_calc_pkg::bcd_t  result_digits [keypad_calc_pkg::NUM_DIGITS],
    output keypad_calc_pkg::seg_t  seg,
    output keypad_calc_pkg::line_t digit_sel,
    output logic                   done
);
    import keypad_calc_pkg::*;

    logic [1:0] tick;
    logic [1:0] sel_idx;
    bcd_t       shown;
    logic       blank;

    //******************************
    // Digit select ring
    //******************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick      <= '0;
            digit_sel <= line_t'(1);  // Units first
        end else if (tick == 2'(DIGIT_TICKS - 1)) begin
            tick      <= '0;
            digit_sel <= {digit_sel[NUM_DIGITS-2:0], digit_sel[NUM_DIGITS-1]};
        end else begin
            tick <= tick + 2'd1;
        end
    end

    // Pick the digit for the selected position
    always_comb begin
        sel_idx = '0;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            if (digit_sel[d]) sel_idx = 2'(d);
        end
        shown = '0;
        blank = 1'b0;
        if (show_result) begin
            shown = result_digits[sel_idx];   // Leading zeros shown
        end else if (sel_idx == 2'd0) begin
            shown = entry_units;
        end else if (sel_idx == 2'd1) begin
            shown = entry_tens;
        end else begin
            blank = 1'b1;
        end
    end

    //******************************
    // Segment decoder
    //******************************
    always_comb begin
        case (shown)
            4'd0:    seg = 7'b0111111;
            4'd1:    seg = 7'b0000110;
            4'd2:    seg = 7'b1011011;
            4'd3:    seg = 7'b1001111;
            4'd4:    seg = 7'b1100110;
            4'd5:    seg = 7'b1101101;
            4'd6:    seg = 7'b1111101;
            4'd7:    seg = 7'b0000111;
            4'd8:    seg = 7'b1111111;
            4'd9:    seg = 7'b1101111;
            default: seg = 7'b0000000;
        endcase
        if (blank) seg = '0;
    end

    assign done = show_result;

endmodule

// File: verilog/keypad_calc_pkg.sv
// Keypad calculator shared definitions
// Widths, key codes, display timing and state types

package keypad_calc_pkg;

    //******************************
    // Sizes and timing
    //******************************
    localparam int ROWS         = 4;   // Keypad rows, also columns
    localparam int NUM_DIGITS   = 4;   // Seven-segment digits
    localparam int OPERAND_BITS = 7;   // Up to 99
    localparam int PRODUCT_BITS = 14;  // Up to 9801
    localparam int DIGIT_TICKS  = 4;   // Cycles per display digit

    //******************************
    // Key codes, row * 4 + column
    //******************************
    localparam int KEY_MUL  = 7;   // B
    localparam int KEY_EQ   = 11;  // C
    localparam int KEY_ZERO = 13;  // 0 key sits in row 3

    typedef logic [ROWS-1:0]         line_t;      // One-hot row, column or digit select
    typedef logic [3:0]              key_code_t;
    typedef logic [3:0]              bcd_t;
    typedef logic [OPERAND_BITS-1:0] operand_t;
    typedef logic [PRODUCT_BITS-1:0] product_t;
    typedef logic [6:0]              seg_t;       // g..a, active high

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } mult_state_t;

    typedef enum logic [1:0] {
        FIRST,
        SECOND,
        RESULT
    } entry_state_t;

endpackage

// File: verilog/keypad_calc_top.sv
// Keypad multiplier top level
// Scanner, entry, multiplier, BCD conversion and display in a chain

`timescale 1ns/1ns

module keypad_calc_top (
    input  logic                   clk,
    input  logic                   rst,
    input  keypad_calc_pkg::line_t col,
    output keypad_calc_pkg::line_t row,
    output keypad_calc_pkg::seg_t  seg,
    output keypad_calc_pkg::line_t digit_sel,
    output logic                   done
);
    import keypad_calc_pkg::*;

    logic      key_valid;
    key_code_t key_code;
    logic      start;
    operand_t  operand_a;
    operand_t  operand_b;
    product_t  product;
    logic      done_pulse;
    bcd_t      entry_tens;
    bcd_t      entry_units;
    logic      show_result;
    bcd_t      result_digits [NUM_DIGITS];

    keypad_scanner u_scanner (
        .clk       (clk),
        .rst       (rst),
        .col       (col),
        .row       (row),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    operand_entry u_entry (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .done_pulse  (done_pulse),
        .start       (start),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .entry_tens  (entry_tens),
        .entry_units (entry_units),
        .show_result (show_result)
    );

    shift_add_multiplier u_mult (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .product    (product),
        .done_pulse (done_pulse)
    );

    bin_to_bcd u_bcd (
        .product       (product),
        .result_digits (result_digits)
    );

    display_mux u_display (
        .clk           (clk),
        .rst           (rst),
        .entry_tens    (entry_tens),
        .entry_units   (entry_units),
        .show_result   (show_result),
        .result_digits (result_digits),
        .seg           (seg),
        .digit_sel     (digit_sel),
        .done          (done)
    );

endmodule

// File: verilog/keypad_scanner.sv
// Keypad scanner
// Drives a one-hot row ring and turns each new press into one key code pulse

`timescale 1ns/1ns

module keypad_scanner (
    input  logic                     clk,
    input  logic                     rst,
    input  keypad_calc_pkg::line_t   col,
    output keypad_calc_pkg::line_t   row,
    output logic                     key_valid,
    output keypad_calc_pkg::key_code_t key_code
);
    import keypad_calc_pkg::*;

    logic            hit;       // Some column active on the current row
    logic [1:0]      row_idx;
    logic [1:0]      col_idx;
    logic [ROWS-1:0] hit_hist;  // Key seen on each of the last ROWS samples

    //******************************
    // Row ring counter
    //******************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row <= line_t'(1);
        end else begin
            row <= {row[ROWS-2:0], row[ROWS-1]};
        end
    end

    // Encode active row and lowest active column
    always_comb begin
        row_idx = '0;
        col_idx = '0;
        for (int i = 0; i < ROWS; i++) begin
            if (row[i]) row_idx = 2'(i);
        end
        for (int j = ROWS - 1; j >= 0; j--) begin
            if (col[j]) col_idx = 2'(j);   // Lowest column wins
        end
        hit = |col;
    end

    //******************************
    // One pulse per press
    //******************************
    // A hit is reported only when a whole scan before it was quiet,
    // so a held key, seen once per scan, never reports twice
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_hist  <= '1;  // Wait for one clean scan
            key_valid <= 1'b0;
        end else begin
            hit_hist  <= {hit_hist[ROWS-2:0], hit};
            key_valid <= hit && (hit_hist == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            key_code <= {row_idx, col_idx};
        end
    end

endmodule

// File: verilog/operand_entry.sv
// Operand entry
// Builds two-digit operands from key codes and starts the multiplier

`timescale 1ns/1ns

module operand_entry (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        key_valid,
    input  keypad_calc_pkg::key_code_t  key_code,
    input  logic                        done_pulse,
    output logic                        start,
    output keypad_calc_pkg::operand_t   operand_a,
    output keypad_calc_pkg::operand_t   operand_b,
    output keypad_calc_pkg::bcd_t       entry_tens,
    output keypad_calc_pkg::bcd_t       entry_units,
    output logic                        show_result
);
    import keypad_calc_pkg::*;

    entry_state_t state;
    logic         busy;      // Multiplier running, keys ignored
    logic         is_digit;
    bcd_t         digit_val;
    operand_t     entry_num;

    // Digit keys sit in rows 0..2, columns 0..2, plus the 0 key
    always_comb begin
        is_digit  = ((key_code[3:2] != 2'd3) && (key_code[1:0] != 2'd3)) ||
                    (key_code == key_code_t'(KEY_ZERO));
        digit_val = (key_code == key_code_t'(KEY_ZERO)) ? '0 :
                    bcd_t'(key_code[3:2]) * 4'd3 + bcd_t'(key_code[1:0]) + 4'd1;
        entry_num = operand_t'(entry_tens) * operand_t'(10) + operand_t'(entry_units);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= FIRST;
            busy        <= 1'b0;
            start       <= 1'b0;
            operand_a   <= '0;
            operand_b   <= '0;
            entry_tens  <= '0;
            entry_units <= '0;
        end else begin
            start <= 1'b0;
            if (busy) begin
                if (done_pulse) begin
                    busy  <= 1'b0;
                    state <= RESULT;
                end
            end else if (key_valid) begin
                if (is_digit) begin
                    if (state == RESULT) begin   // Fresh calculation
                        operand_a  <= '0;
                        operand_b  <= '0;
                        entry_tens <= '0;
                        state      <= FIRST;
                    end else begin
                        entry_tens <= entry_units; // Oldest digit drops off
                    end
                    entry_units <= digit_val;
                end else if (state == FIRST && key_code == key_code_t'(KEY_MUL)) begin
                    operand_a   <= entry_num;
                    entry_tens  <= '0;
                    entry_units <= '0;
                    state       <= SECOND;
                end else if (state == SECOND && key_code == key_code_t'(KEY_EQ)) begin
                    operand_b <= entry_num;
                    start     <= 1'b1;
                    busy      <= 1'b1;
                end
            end
        end
    end

    assign show_result = (state == RESULT);

endmodule

// File: verilog/shift_add_multiplier.sv
// Shift-add multiplier
// Unsigned sequential product of two operands, one add-and-shift per cycle

`timescale 1ns/1ns

module shift_add_multiplier (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  keypad_calc_pkg::operand_t operand_a,
    input  keypad_calc_pkg::operand_t operand_b,
    output keypad_calc_pkg::product_t product,
    output logic                      done_pulse
);
    import keypad_calc_pkg::*;

    mult_state_t state;
    logic [2:0]  step_cnt;
    logic        last_step;
    product_t    mcand;     // Multiplicand, shifts left
    operand_t    mplier;    // Multiplier, shifts right
    product_t    acc;
    product_t    acc_next;

    assign acc_next  = mplier[0] ? acc + mcand : acc;
    assign last_step = (step_cnt == 3'(OPERAND_BITS - 1));

    //******************************
    // Control
    //******************************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state    <= RUN;
                        step_cnt <= '0;
                    end else begin
                        state <= IDLE;
                    end
                end
                RUN: begin
                    step_cnt <= step_cnt + 3'd1;
                    if (last_step) state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    //******************************
    // Datapath
    //******************************
    always_ff @(posedge clk) begin
        if (state != RUN && start) begin
            mcand  <= product_t'(operand_a);
            mplier <= operand_b;
            acc    <= '0;
        end else if (state == RUN) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Result held until the next operation finishes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            product <= '0;
        end else if (state == RUN && last_step) begin
            product <= acc_next;
        end
    end

    assign done_pulse = (state == DONE);

endmodule
